// ==== ru_block_pkg.sv ====
`default_nettype none

package ru_block_pkg;

    // width of every word moved to or from the remote-update block
    localparam int RU_DATA_W = 22;

    typedef logic [RU_DATA_W-1:0] ru_data_t;

    // parameter selector, as the block decodes it
    typedef logic [2:0] ru_param_t;

    localparam ru_param_t RU_PARAM_WATCHDOG_EN  = 3'b001;
    localparam ru_param_t RU_PARAM_BOOT_ADDR    = 3'b011;
    localparam ru_param_t RU_PARAM_WATCHDOG_VAL = 3'b100;
    // upper vector bit of the boot image select
    localparam ru_param_t RU_PARAM_VECTOR1      = 3'b110;

    // read source, current state or the written input registers
    typedef logic [1:0] ru_source_t;

    localparam ru_source_t RU_SRC_CURRENT = 2'b00;
    localparam ru_source_t RU_SRC_INPUT   = 2'b11;

    // everything the controller drives into the block
    typedef struct packed {
        ru_param_t  param;
        ru_data_t   data_in;
        logic       write_param;
        logic       read_param;
        ru_source_t read_source;
    } ru_cmd_t;

    // what comes back from the block
    typedef struct packed {
        logic     busy;
        ru_data_t data_out;
    } ru_status_t;

endpackage

`default_nettype wire

// ==== ru_ctrl_pkg.sv ====
`default_nettype none

package ru_ctrl_pkg;

    // number of parameter writes sent before any read-back
    localparam int SEQ_WRITES = 4;

    // number of read-back commands after the writes
    localparam int SEQ_READS = 2;

    // press counter width, enough for thresholds up to 15
    localparam int PRESS_CNT_W = 4;

    // sequencer steps, writes first, then reads, then done
    // encoding order matters, the sequencer advances by +1
    // and splits write/read steps on the SEQ_WRITES boundary
    typedef enum logic [2:0] {
        // watchdog enable cleared
        SEQ_WR_WD_EN     = 3'd0,
        // watchdog timeout value cleared
        SEQ_WR_WD_VAL    = 3'd1,
        // vector bit 1 cleared
        SEQ_WR_VECTOR1   = 3'd2,
        // boot address of the next image
        SEQ_WR_BOOT_ADDR = 3'd3,
        // read back watchdog enable from the input regs
        SEQ_RD_WD_EN     = 3'd4,
        // read back watchdog value from the input regs
        SEQ_RD_WD_VAL    = 3'd5,
        // nothing left to send
        SEQ_DONE         = 3'd6
    } seq_step_t;

endpackage

`default_nettype wire

// ==== switch_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_trigger
    import ru_ctrl_pkg::*;
#(
    parameter int unsigned PRESS_COUNT = 8
)
(
    input  wire logic spi_clk,
    input  wire logic reset_n,
    input  wire logic switch_i,
    output logic      armed_o
);

    // two-stage sync of the board switch
    logic [1:0]             sync_q;
    // one-cycle pulse per rising edge
    logic                   rise_q;
    logic [PRESS_CNT_W-1:0] press_cnt_q;
    logic                   armed_q;
    logic                   cnt_full;

    // threshold reached, counter stops here
    assign cnt_full = (press_cnt_q == PRESS_CNT_W'(PRESS_COUNT));

    always_ff @(posedge spi_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            sync_q      <= '0;
            rise_q      <= 1'b0;
            press_cnt_q <= '0;
            armed_q     <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[0], switch_i};
            // edge pulse from new vs old synced level
            rise_q <= sync_q[0] & ~sync_q[1];
            // saturating press count, extra presses ignored
            if (rise_q && !cnt_full)
            begin
                press_cnt_q <= press_cnt_q + 1'b1;
            end
            // sticky, one cycle after the count hits the threshold
            armed_q <= armed_q | cnt_full;
        end
    end

    assign armed_o = armed_q;

endmodule

`default_nettype wire

// ==== param_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_sequencer
    import ru_block_pkg::*;
    import ru_ctrl_pkg::*;
#(
    parameter ru_data_t BOOT_ADDR = 22'h10000
)
(
    input  wire logic     spi_clk,
    input  wire logic     reset_n,
    input  wire logic     busy_i,
    input  wire ru_data_t data_out_i,
    output ru_cmd_t       cmd_o,
    output ru_data_t      rdata_o,
    output logic          rdata_valid_o,
    output logic          seq_done_o
);

    // step of the command in flight, or the next one to send
    seq_step_t step_q;
    seq_step_t step_nxt;
    // command sent, waiting for busy high then low
    logic      wait_q;
    logic      seen_busy_q;
    logic      busy_done;
    logic      issue;
    logic      nxt_is_write;
    logic      nxt_is_read;
    logic      cur_is_read;
    ru_param_t nxt_param;
    ru_data_t  nxt_data;
    ru_cmd_t   cmd_q;
    ru_data_t  rdata_q;
    logic      rdata_valid_q;
    logic      seq_done_q;

    // busy has been seen and has now dropped
    assign busy_done = wait_q & seen_busy_q & ~busy_i;
    assign step_nxt  = busy_done ? seq_step_t'(step_q + 3'd1) : step_q;

    // write steps sit below SEQ_WRITES, reads right after them
    assign nxt_is_write = int'(step_nxt) < SEQ_WRITES;
    assign nxt_is_read  = (int'(step_nxt) >= SEQ_WRITES) &&
                          (int'(step_nxt) < SEQ_WRITES + SEQ_READS);
    assign cur_is_read  = (int'(step_q) >= SEQ_WRITES) &&
                          (int'(step_q) < SEQ_WRITES + SEQ_READS);

    // new pulse right after the previous one completes, never while busy
    assign issue = (!wait_q || busy_done) && (step_nxt != SEQ_DONE) && !busy_i;

    // parameter and data per step
    always_comb
    begin
        nxt_param = RU_PARAM_WATCHDOG_EN;
        nxt_data  = '0;
        case (step_nxt)
            SEQ_WR_WD_VAL:    nxt_param = RU_PARAM_WATCHDOG_VAL;
            SEQ_WR_VECTOR1:   nxt_param = RU_PARAM_VECTOR1;
            SEQ_WR_BOOT_ADDR:
            begin
                nxt_param = RU_PARAM_BOOT_ADDR;
                nxt_data  = BOOT_ADDR;
            end
            SEQ_RD_WD_VAL:    nxt_param = RU_PARAM_WATCHDOG_VAL;
            default:          nxt_param = RU_PARAM_WATCHDOG_EN;
        endcase
    end

    always_ff @(posedge spi_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            step_q        <= SEQ_WR_WD_EN;
            wait_q        <= 1'b0;
            seen_busy_q   <= 1'b0;
            cmd_q         <= '{param: RU_PARAM_WATCHDOG_EN, data_in: '0, write_param: 1'b0,
                               read_param: 1'b0, read_source: RU_SRC_CURRENT};
            rdata_valid_q <= 1'b0;
            seq_done_q    <= 1'b0;
        end
        else
        begin
            step_q <= step_nxt;
            // wait tracking, cleared on every new pulse
            if (issue)
            begin
                wait_q      <= 1'b1;
                seen_busy_q <= 1'b0;
                cmd_q.param   <= nxt_param;
                cmd_q.data_in <= nxt_data;
            end
            else
            begin
                if (busy_done)
                begin
                    wait_q <= 1'b0;
                end
                if (wait_q && busy_i)
                begin
                    seen_busy_q <= 1'b1;
                end
            end
            // single-cycle command strobes
            cmd_q.write_param <= issue & nxt_is_write;
            cmd_q.read_param  <= issue & nxt_is_read;
            // input regs as source only across the read steps
            cmd_q.read_source <= nxt_is_read ? RU_SRC_INPUT : RU_SRC_CURRENT;
            rdata_valid_q     <= busy_done & cur_is_read;
            seq_done_q        <= seq_done_q | (step_nxt == SEQ_DONE);
        end
    end

    // read word, valid in the cycle busy falls
    always_ff @(posedge spi_clk)
    begin
        if (busy_done && cur_is_read)
        begin
            rdata_q <= data_out_i;
        end
    end

    assign cmd_o         = cmd_q;
    assign rdata_o       = rdata_q;
    assign rdata_valid_o = rdata_valid_q;
    assign seq_done_o    = seq_done_q;

endmodule

`default_nettype wire

// ==== reconfig_launcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module reconfig_launcher
(
    input  wire logic spi_clk,
    input  wire logic reset_n,
    input  wire logic armed_i,
    input  wire logic seq_done_i,
    input  wire logic busy_i,
    output logic      reconfig_o
);

    // launch request, sticky until the next reset
    logic launch_q;
    logic launch_ok;

    // switch armed, parameters written and read back, block idle
    assign launch_ok = armed_i & seq_done_i & ~busy_i;

    always_ff @(posedge spi_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            launch_q <= 1'b0;
        end
        else if (launch_ok)
        begin
            launch_q <= 1'b1;
        end
    end

    // held high so the block sees a stable request
    assign reconfig_o = launch_q;

endmodule

`default_nettype wire

// ==== remote_update_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module remote_update_ctrl
    import ru_block_pkg::*;
#(
    parameter ru_data_t    BOOT_ADDR   = 22'h10000,
    parameter int unsigned PRESS_COUNT = 8
)
(
    input  wire logic       spi_clk,
    input  wire logic       reset_n,
    input  wire logic       switch_i,
    input  wire ru_status_t status_i,
    output ru_cmd_t         cmd_o,
    output logic            reconfig_o,
    output ru_data_t        rdata_o,
    output logic            rdata_valid_o
);

    // sticky flags into the launcher
    logic armed;
    logic seq_done;

    // switch presses, counted to the arm threshold
    switch_trigger #(
        .PRESS_COUNT (PRESS_COUNT)
    ) u_switch_trigger (
        .spi_clk  (spi_clk),
        .reset_n  (reset_n),
        .switch_i (switch_i),
        .armed_o  (armed)
    );

    // fixed write / read-back sequence towards the block
    param_sequencer #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_param_sequencer (
        .spi_clk       (spi_clk),
        .reset_n       (reset_n),
        .busy_i        (status_i.busy),
        .data_out_i    (status_i.data_out),
        .cmd_o         (cmd_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .seq_done_o    (seq_done)
    );

    // launch once both are ready and the block is idle
    reconfig_launcher u_reconfig_launcher (
        .spi_clk    (spi_clk),
        .reset_n    (reset_n),
        .armed_i    (armed),
        .seq_done_i (seq_done),
        .busy_i     (status_i.busy),
        .reconfig_o (reconfig_o)
    );

endmodule

`default_nettype wire

// ==== ru_block_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ru_block_model
    import ru_block_pkg::*;
(
    input  wire logic       spi_clk,
    input  wire logic       reset_n,
    input  wire ru_cmd_t    cmd_i,
    input  wire logic [3:0] busy_len_i,
    input  wire ru_data_t   rd_word0_i,
    input  wire ru_data_t   rd_word1_i,
    output ru_status_t      status_o,
    output logic            overlap_o,
    output logic            long_o
);

    // every command seen, in arrival order
    ru_cmd_t    cmd_log [0:7];
    int         cmd_cnt;
    int         rd_cnt;
    logic       busy_q;
    logic [3:0] busy_cnt_q;
    // read in flight, data goes out when busy drops
    logic       rd_pend_q;
    ru_data_t   data_q;
    logic       strobe;
    logic       strobe_prev_q;

    assign strobe = cmd_i.write_param | cmd_i.read_param;

    always_ff @(posedge spi_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            cmd_cnt       <= 0;
            rd_cnt        <= 0;
            busy_q        <= 1'b0;
            busy_cnt_q    <= '0;
            rd_pend_q     <= 1'b0;
            data_q        <= '0;
            strobe_prev_q <= 1'b0;
            overlap_o     <= 1'b0;
            long_o        <= 1'b0;
        end
        else
        begin
            strobe_prev_q <= strobe;
            if (strobe)
            begin
                // protocol breaks, sticky until reset
                if (busy_q)
                begin
                    overlap_o <= 1'b1;
                end
                if (strobe_prev_q)
                begin
                    long_o <= 1'b1;
                end
                if (cmd_cnt < 8)
                begin
                    cmd_log[cmd_cnt[2:0]] <= cmd_i;
                end
                cmd_cnt    <= cmd_cnt + 1;
                // busy from the next cycle, busy_len_i cycles long
                busy_q     <= 1'b1;
                busy_cnt_q <= busy_len_i - 4'd1;
                rd_pend_q  <= cmd_i.read_param;
            end
            else if (busy_q)
            begin
                if (busy_cnt_q == 4'd0)
                begin
                    busy_q <= 1'b0;
                    // read word valid in the first idle cycle
                    if (rd_pend_q)
                    begin
                        data_q <= (rd_cnt == 0) ? rd_word0_i : rd_word1_i;
                        rd_cnt <= rd_cnt + 1;
                    end
                end
                else
                begin
                    busy_cnt_q <= busy_cnt_q - 4'd1;
                end
            end
        end
    end

    assign status_o = '{busy: busy_q, data_out: data_q};

endmodule

`default_nettype wire

// ==== tb_remote_update_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_remote_update_ctrl
    import ru_block_pkg::*;
    import ru_ctrl_pkg::*;
();

    localparam int       PRESS_COUNT_CFG = 3;
    localparam ru_data_t BOOT_ADDR_CFG   = 22'h2A5C0;
    localparam int       MAX_CASES       = 16;

    logic        spi_clk;
    logic        reset_n;
    logic        switch_i;
    ru_status_t  status;
    ru_cmd_t     dut_cmd;
    logic        reconfig;
    ru_data_t    rdata;
    logic        rdata_valid;
    logic [3:0]  busy_len = 4'd2;
    ru_data_t    rd_word0;
    ru_data_t    rd_word1;
    logic        overlap;
    logic        long_pulse;
    integer      seed = 64;

    // cases from the data file
    ru_data_t    case_boot    [MAX_CASES];
    int          case_presses [MAX_CASES];
    ru_data_t    case_w0      [MAX_CASES];
    ru_data_t    case_w1      [MAX_CASES];
    int          n_cases;
    int          cur_presses;
    // monitor state
    int          rv_cnt;
    logic        reconfig_prev;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;

    remote_update_ctrl #(
        .BOOT_ADDR   (BOOT_ADDR_CFG),
        .PRESS_COUNT (PRESS_COUNT_CFG)
    ) dut0 (
        .spi_clk       (spi_clk),
        .reset_n       (reset_n),
        .switch_i      (switch_i),
        .status_i      (status),
        .cmd_o         (dut_cmd),
        .reconfig_o    (reconfig),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid)
    );

    ru_block_model model0 (
        .spi_clk    (spi_clk),
        .reset_n    (reset_n),
        .cmd_i      (dut_cmd),
        .busy_len_i (busy_len),
        .rd_word0_i (rd_word0),
        .rd_word1_i (rd_word1),
        .status_o   (status),
        .overlap_o  (overlap),
        .long_o     (long_pulse)
    );

    initial
    begin
        spi_clk = 1'b0;
        forever #4 spi_clk = ~spi_clk;
    end

    task automatic fail_run(string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_cmd(string name, ru_cmd_t exp, ru_cmd_t act);
        if (act !== exp)
            fail_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_data(string name, ru_data_t exp, ru_data_t act);
        if (act !== exp)
            fail_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            fail_run($sformatf("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic check_source(string name, ru_source_t exp, ru_source_t act);
        if (act !== exp)
            fail_run($sformatf("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    // command n of the fixed write / read-back order
    function automatic ru_cmd_t expected_cmd(int idx, ru_data_t boot);
        ru_cmd_t c;
        c             = '0;
        c.read_source = RU_SRC_CURRENT;
        c.write_param = (idx < SEQ_WRITES);
        c.read_param  = (idx >= SEQ_WRITES);
        case (idx)
            0: c.param = RU_PARAM_WATCHDOG_EN;
            1: c.param = RU_PARAM_WATCHDOG_VAL;
            2: c.param = RU_PARAM_VECTOR1;
            3:
            begin
                c.param   = RU_PARAM_BOOT_ADDR;
                c.data_in = boot;
            end
            4:
            begin
                c.param       = RU_PARAM_WATCHDOG_EN;
                c.read_source = RU_SRC_INPUT;
            end
            default:
            begin
                c.param       = RU_PARAM_WATCHDOG_VAL;
                c.read_source = RU_SRC_INPUT;
            end
        endcase
        return c;
    endfunction

    // new busy length for every command the block takes
    always @(posedge spi_clk)
    begin
        if (dut_cmd.write_param || dut_cmd.read_param)
            busy_len <= 4'(2 + ($unsigned($random(seed)) % 8));
    end

    always @(posedge spi_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
            fail_run($sformatf("timeout, run went past %0d cycles", cycle_limit));
    end

    // read-back and launch watch on every cycle out of reset
    always @(posedge spi_clk)
    begin
        if (!reset_n)
        begin
            rv_cnt        <= 0;
            reconfig_prev <= 1'b0;
        end
        else
        begin
            if (overlap)
                fail_run("block model got a command while busy was high");
            if (long_pulse)
                fail_run("block model got a command strobe held for two cycles");
            if (rdata_valid)
            begin
                if (rv_cnt >= SEQ_READS)
                    fail_run("more than two read-back pulses on rdata_valid_o");
                check_data("rdata_o", (rv_cnt == 0) ? rd_word0 : rd_word1, rdata);
                rv_cnt <= rv_cnt + 1;
            end
            if (reconfig && !reconfig_prev)
            begin
                if (cur_presses < PRESS_COUNT_CFG)
                    fail_run($sformatf("reconfig_o rose after only %0d presses", cur_presses));
                if (rv_cnt != SEQ_READS)
                    fail_run("reconfig_o rose before the last read-back completed");
            end
            if (!reconfig && reconfig_prev)
                fail_run("reconfig_o dropped before reset");
            reconfig_prev <= reconfig;
        end
    end

    task automatic run_case(int c);
        int   gap;
        logic exp_launch;
        @(posedge spi_clk);
        reset_n  <= 1'b0;
        switch_i <= 1'b0;
        rd_word0 <= case_w0[c];
        rd_word1 <= case_w1[c];
        cur_presses = case_presses[c];
        exp_launch  = (case_presses[c] >= PRESS_COUNT_CFG);
        repeat (10) @(posedge spi_clk);
        // reset values before release
        check_bit("reconfig_o", 1'b0, reconfig);
        check_bit("rdata_valid_o", 1'b0, rdata_valid);
        check_bit("cmd_o.write_param", 1'b0, dut_cmd.write_param);
        check_bit("cmd_o.read_param", 1'b0, dut_cmd.read_param);
        check_source("cmd_o.read_source", RU_SRC_CURRENT, dut_cmd.read_source);
        reset_n <= 1'b1;
        check_data("case boot address", BOOT_ADDR_CFG, case_boot[c]);
        // presses with random low and high times
        for (int i = 0; i < case_presses[c]; i++)
        begin
            gap = 3 + int'($unsigned($random(seed)) % 16);
            repeat (gap) @(posedge spi_clk);
            switch_i <= 1'b1;
            gap = 3 + int'($unsigned($random(seed)) % 16);
            repeat (gap) @(posedge spi_clk);
            switch_i <= 1'b0;
        end
        while (rv_cnt < SEQ_READS)
            @(posedge spi_clk);
        if (exp_launch)
        begin
            while (!reconfig)
                @(posedge spi_clk);
        end
        // window for a late launch or a dropped request
        repeat (12) @(posedge spi_clk);
        check_bit("reconfig_o", exp_launch, reconfig);
        if (model0.cmd_cnt != SEQ_WRITES + SEQ_READS)
            fail_run($sformatf("block got %0d commands instead of six", model0.cmd_cnt));
        for (int i = 0; i < SEQ_WRITES + SEQ_READS; i++)
            check_cmd($sformatf("cmd_o #%0d", i), expected_cmd(i, case_boot[c]),
                      model0.cmd_log[i]);
    endtask

    initial
    begin
        int          fd;
        int          code;
        ru_data_t    boot_v;
        int          presses_v;
        ru_data_t    w0_v;
        ru_data_t    w1_v;
        int unsigned limit;
        reset_n  = 1'b0;
        switch_i = 1'b0;
        rd_word0 = '0;
        rd_word1 = '0;
        cur_presses = 0;
        n_cases  = 0;
        fd = $fopen("remote_update_cases.txt", "r");
        if (fd == 0)
            fail_run("cannot open remote_update_cases.txt");
        code = $fscanf(fd, " %h %d %h %h", boot_v, presses_v, w0_v, w1_v);
        while (code == 4 && n_cases < MAX_CASES)
        begin
            case_boot[n_cases]    = boot_v;
            case_presses[n_cases] = presses_v;
            case_w0[n_cases]      = w0_v;
            case_w1[n_cases]      = w1_v;
            n_cases++;
            code = $fscanf(fd, " %h %d %h %h", boot_v, presses_v, w0_v, w1_v);
        end
        $fclose(fd);
        if (n_cases == 0)
            fail_run("no cases found in remote_update_cases.txt");
        // budget of presses plus six commands per case
        limit = 300;
        for (int c = 0; c < n_cases; c++)
            limit += 32'(case_presses[c] * 40 + 6 * 14);
        cycle_limit = limit;
        for (int c = 0; c < n_cases; c++)
            run_case(c);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== remote_update_cases.txt ====
2a5c0 3 000000 0a5a5a
2a5c0 0 000001 3fffff
2a5c0 2 155555 2aaaaa
2a5c0 5 3c0ffe 001234
2a5c0 1 0abcde 300001
2a5c0 4 123456 054321
2a5c0 3 3fffff 000000

// ==== build.f ====
ru_block_pkg.sv
ru_ctrl_pkg.sv
switch_trigger.sv
param_sequencer.sv
reconfig_launcher.sv
remote_update_ctrl.sv
ru_block_model.sv
tb_remote_update_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_remote_update_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
